// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f --top-module tb_wms_io -Mdir obj_dir

run: compile
	./obj_dir/Vtb_wms_io +verilator+error+limit+1000 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "Run reported failure, see sim.log"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "Run ended without a result line, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
rtl/wms_pkg.sv
rtl/kbd_decode.sv
rtl/cfg_loader.sv
rtl/stick_quantizer.sv
rtl/control_mapper.sv
rtl/blank_gen.sv
rtl/wms_io_top.sv
dv/wms_io_asserts.sv
dv/tb_wms_io.sv

// ==== dv/tb_wms_io.sv ====
/*
 * Testbench for wms_io_top
 * Clock, reset, sync timing, config writes, per-game control stimulus
 * and the closing report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wms_io;

	logic               clk_sys;
	logic               arst_n;
	wms_pkg::kbd_evt_t  kbd;
	wms_pkg::usb_joy_t  joy1;
	wms_pkg::usb_joy_t  joy2;
	wms_pkg::analog_t   stick;
	logic               fire_mode;
	logic               cfg_req;
	wms_pkg::cfg_wr_t   cfg_data;
	logic               hs;
	logic               vs;
	logic               cfg_ack;
	wms_pkg::cab_ctrl_t cab;
	logic [7:0]         dip_sw;
	logic               hblank;
	logic               vblank;

	logic [31:0]        lfsr;
	int unsigned        timeouts;
	int unsigned        assert_fails;

	wms_io_top #(
		.CNT_W (11)
	) wms_io_top_inst
	(
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.kbd       (kbd),
		.joy1      (joy1),
		.joy2      (joy2),
		.stick     (stick),
		.fire_mode (fire_mode),
		.cfg_req   (cfg_req),
		.cfg_data  (cfg_data),
		.hs        (hs),
		.vs        (vs),
		.cfg_ack   (cfg_ack),
		.cab       (cab),
		.dip_sw    (dip_sw),
		.hblank    (hblank),
		.vblank    (vblank)
	);

	bind wms_io_top wms_io_asserts wms_io_asserts_inst
	(
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cfg_req   (cfg_req),
		.cfg_ack   (cfg_ack),
		.cfg_data  (cfg_data),
		.game      (game),
		.dip_sw    (dip_sw),
		.kbd       (kbd),
		.joy1      (joy1),
		.joy2      (joy2),
		.stick     (stick),
		.fire_mode (fire_mode),
		.cab       (cab),
		.hs        (hs),
		.vs        (vs),
		.hblank    (hblank),
		.vblank    (vblank)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	task automatic advance(input int n);
		repeat (n)
		begin
			@(posedge clk_sys);
			#5;
		end
	endtask

	task automatic cfg_write(input logic [7:0] idx, input logic [2:0] sub, input logic [7:0] val);
		int n;
		advance(1);
		cfg_data.index = idx;
		cfg_data.addr  = sub;
		cfg_data.data  = val;
		cfg_req        = 1'b1;
		n = 0;
		while (!cfg_ack && n < 50)
		begin
			advance(1);
			n++;
		end
		if (!cfg_ack)
		begin
			timeouts++;
			$display("Timeout at %0t: cfg_ack never rose for index %0d", $time, idx);
		end
		cfg_req = 1'b0;
		n = 0;
		while (cfg_ack && n < 50)
		begin
			advance(1);
			n++;
		end
		if (cfg_ack)
		begin
			timeouts++;
			$display("Timeout at %0t: cfg_ack stuck high after cfg_req dropped", $time);
		end
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		advance(1);
		kbd.code    = code;
		kbd.pressed = pressed;
		kbd.toggle  = ~kbd.toggle;
		advance(4);
	endtask

	task automatic wait_vblank(input logic level);
		int n;
		n = 0;
		while (vblank != level && n < 300000)
		begin
			advance(1);
			n++;
		end
		if (vblank != level)
		begin
			timeouts++;
			$display("Timeout at %0t: vblank never reached %0b", $time, level);
		end
	endtask

	// Sync pulses of 800 clocks per line and 262 lines per frame
	initial
	begin : sync_drive
		int pcnt;
		int lcnt;
		pcnt = 0;
		lcnt = 0;
		hs   = 1'b0;
		vs   = 1'b0;
		forever
		begin
			@(posedge clk_sys);
			#5;
			hs   = pcnt < 64;
			vs   = lcnt < 3;
			pcnt = (pcnt == 799) ? 0 : pcnt + 1;
			if (pcnt == 0)
				lcnt = (lcnt == 261) ? 0 : lcnt + 1;
		end
	end

	initial
	begin : stimulus
		logic [7:0] rx;
		logic [7:0] ry;
		logic [7:0] rj;
		arst_n    = 1'b0;
		kbd       = '0;
		joy1      = '0;
		joy2      = '0;
		stick     = '0;
		fire_mode = 1'b1;
		cfg_req   = 1'b0;
		cfg_data  = '0;
		lfsr      = 32'hcfbe;
		timeouts  = 0;
		repeat (16) @(posedge clk_sys);
		#5;
		arst_n = 1'b1;
		advance(4);

		// DIP byte followed by writes that must be ignored
		cfg_write(8'd254, 3'd0, 8'hA5);
		cfg_write(8'd254, 3'd3, 8'h3C);
		cfg_write(8'd7, 3'd0, 8'h5A);

		// Robotron keyboard up then 4-way firing
		cfg_write(8'd1, 3'd0, 8'd0);
		key_event(8'h75, 1'b1);
		key_event(8'h75, 1'b0);
		fire_mode = 1'b0;
		joy1.p.fire_a = 1'b1;
		advance(4);
		joy1.p.fire_a = 1'b0;
		fire_mode = 1'b1;
		joy2.p.right = 1'b1;
		joy2.p.down  = 1'b1;
		joy1.start1  = 1'b1;
		advance(4);
		joy2 = '0;
		joy1 = '0;

		// Joust player 2 flap and start/coin order
		cfg_write(8'd1, 3'd0, 8'd1);
		joy2.p.fire_a = 1'b1;
		joy2.start2   = 1'b1;
		advance(4);
		joy2 = '0;
		joy1.coin = 1'b1;
		joy1.p.left = 1'b1;
		advance(4);
		joy1 = '0;

		// Bubbles
		cfg_write(8'd1, 3'd0, 8'd3);
		joy1.p.up   = 1'b1;
		joy1.start1 = 1'b1;
		advance(4);
		joy1 = '0;

		// Sinistar random stick with some digital directions
		cfg_write(8'd1, 3'd0, 8'd6);
		for (int i = 0; i < 64; i++)
		begin
			random_byte(rx);
			random_byte(ry);
			random_byte(rj);
			stick.x = rx;
			stick.y = ry;
			joy1.p  = {4'b0000, rj[3:0]};
			advance(3);
		end
		joy1  = '0;
		stick = '0;
		key_event(8'h6B, 1'b1);
		joy2.p.fire_a = 1'b1;
		joy2.p.fire_b = 1'b1;
		advance(4);
		joy2 = '0;
		key_event(8'h6B, 1'b0);

		// Unknown game code
		cfg_write(8'd1, 3'd0, 8'd5);
		joy1 = 11'h7FF;
		advance(4);
		joy1 = '0;

		// Let a full frame of blanking pass
		wait_vblank(1'b0);
		wait_vblank(1'b1);
		wait_vblank(1'b0);
		advance(10);

		assert_fails = wms_io_top_inst.wms_io_asserts_inst.fail_cnt;
		$display("Closing report: %0d assertion failures, %0d timeouts", assert_fails, timeouts);
		if (assert_fails == 0 && timeouts == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/wms_io_asserts.sv ====
/*
 * Concurrent checks bound into wms_io_top
 * Config handshake, per-game cabinet mapping, Sinistar stick codes
 * and blanking, with small reference counters for the sync timing
 */
`timescale 1ns/1ps
`default_nettype none

module wms_io_asserts
(
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wire                cfg_req,
	input  wire                cfg_ack,
	input  wms_pkg::cfg_wr_t   cfg_data,
	input  wms_pkg::game_e     game,
	input  wire [7:0]          dip_sw,
	input  wms_pkg::kbd_evt_t  kbd,
	input  wms_pkg::usb_joy_t  joy1,
	input  wms_pkg::usb_joy_t  joy2,
	input  wms_pkg::analog_t   stick,
	input  wire                fire_mode,
	input  wms_pkg::cab_ctrl_t cab,
	input  wire                hs,
	input  wire                vs,
	input  wire                hblank,
	input  wire                vblank
);

	int unsigned fail_cnt = 0;

	// Keyboard model tracks only 75 up and 6B left
	logic             tog_q;
	logic             kb_up;
	logic             kb_left;
	logic             hs_q;
	logic             vs_q;
	logic [10:0]      pix;
	logic [10:0]      line;
	wms_pkg::player_t sh;
	logic [3:0]       dirs;
	logic [3:0]       ax;
	logic [3:0]       ay;
	logic [7:0]       sin_ja;
	logic [7:0]       joust_ja;
	logic [7:0]       joust_jb;
	logic [2:0]       btn_std;
	logic [2:0]       btn_alt;
	logic             dip_hit;
	logic [7:0]       dip_next;
	logic             game_hit;
	logic             known_game;
	logic             hbl_exp;
	logic             vbl_exp;

	function automatic logic [3:0] quant_x(input int v);
		if (v < -96) return 4'd0;
		if (v < -64) return 4'd4;
		if (v < -32) return 4'd6;
		if (v > 96) return 4'd8;
		if (v > 64) return 4'd9;
		if (v > 32) return 4'd11;
		return 4'd7;
	endfunction

	function automatic logic [3:0] quant_y(input int v);
		if (v < -96) return 4'd8;
		if (v < -64) return 4'd9;
		if (v < -32) return 4'd11;
		if (v > 96) return 4'd0;
		if (v > 64) return 4'd4;
		if (v > 32) return 4'd6;
		return 4'd7;
	endfunction

	task automatic count_fail(input string msg);
		fail_cnt++;
		$error("ERROR %0t: %s", $time, msg);
	endtask

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tog_q   <= 1'b0;
			kb_up   <= 1'b0;
			kb_left <= 1'b0;
			hs_q    <= 1'b0;
			vs_q    <= 1'b0;
			pix     <= '0;
			line    <= '0;
		end
		else
		begin
			tog_q <= kbd.toggle;
			if (kbd.toggle != tog_q && kbd.code == 8'h75)
				kb_up <= kbd.pressed;
			if (kbd.toggle != tog_q && kbd.code == 8'h6B)
				kb_left <= kbd.pressed;
			hs_q <= hs;
			if (pix != 11'h7FF)
				pix <= pix + 11'd1;
			if (hs && !hs_q)
			begin
				pix  <= '0;
				vs_q <= vs;
				if (vs && !vs_q)
					line <= '0;
				else if (line != 11'h7FF)
					line <= line + 11'd1;
			end
		end
	end

	assign sh         = joy1.p | joy2.p | {4'b0000, kb_up, 1'b0, kb_left, 1'b0};
	assign dirs       = {sh.right, sh.left, sh.down, sh.up};
	assign ax         = quant_x(int'(stick.x));
	assign ay         = quant_y(int'(stick.y));
	assign sin_ja[7:4] = (ax != 4'd7) ? ax : sh.left ? 4'd0 : sh.right ? 4'd8 : 4'd7;
	assign sin_ja[3:0] = (ay != 4'd7) ? ay : sh.down ? 4'd0 : sh.up ? 4'd8 : 4'd7;
	assign joust_ja   = {5'b00000, joy1.p.fire_a, joy1.p.right, joy1.p.left | kb_left};
	assign joust_jb   = {5'b00000, joy2.p.fire_a, joy2.p.right, joy2.p.left};
	assign btn_std    = {joy1.start1 | joy2.start1, joy1.start2 | joy2.start2, joy1.coin | joy2.coin};
	assign btn_alt    = {btn_std[1], btn_std[2], btn_std[0]};
	assign dip_hit    = cfg_req && !cfg_ack && cfg_data.index == 8'd254 && cfg_data.addr == 3'd0;
	assign dip_next   = dip_hit ? cfg_data.data : dip_sw;
	assign game_hit   = cfg_req && !cfg_ack && cfg_data.index == 8'd1;
	assign known_game = game == wms_pkg::ROBOTRON || game == wms_pkg::JOUST ||
		game == wms_pkg::BUBBLES || game == wms_pkg::SINISTAR;
	// Blanking spans half-pixels 336..40 and lines 246..6 one edge behind the count
	assign hbl_exp    = pix >= 11'd672 || pix < 11'd80;
	assign vbl_exp    = line >= 11'd246 || line < 11'd6;

	//////////////////////////////////////////////////////////////////////
	// Config channel
	a_ack_rise: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(cfg_ack) |-> $past(cfg_req)) else count_fail("cfg_ack rose without cfg_req");
	a_ack_fall: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(cfg_ack) |-> !$past(cfg_req)) else count_fail("cfg_ack fell while cfg_req high");
	a_dip: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dip_sw == $past(dip_next)) else count_fail("dip_sw wrong after config write");
	a_game: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game_hit |=> game == $past(cfg_data.data)) else count_fail("game not loaded at ack");

	//////////////////////////////////////////////////////////////////////
	// Cabinet mapping one registered edge after the inputs
	a_jb_copy: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game != wms_pkg::JOUST |=> cab.jb == cab.ja) else count_fail("jb differs from ja");
	a_robo_dir: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::ROBOTRON |=> cab.ja[3:0] == ~$past(dirs))
		else count_fail("Robotron move bits wrong");
	a_robo_fire1: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::ROBOTRON && fire_mode |=> cab.ja[7:4] == ~$past(dirs))
		else count_fail("Robotron 4-way fire bits wrong");
	a_robo_fire0: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::ROBOTRON && !fire_mode |=> cab.ja[7] == !$past(sh.fire_a))
		else count_fail("Robotron fire_a bit wrong");
	a_btn_std: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::ROBOTRON || game == wms_pkg::SINISTAR |=> cab.btn == $past(btn_std))
		else count_fail("start/coin order wrong");
	a_btn_alt: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::JOUST || game == wms_pkg::BUBBLES |=> cab.btn == $past(btn_alt))
		else count_fail("start/coin order wrong");
	a_joust: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::JOUST |=> cab.ja == ~$past(joust_ja) && cab.jb == ~$past(joust_jb))
		else count_fail("Joust player mapping wrong");
	a_bubbles: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::BUBBLES |=> cab.ja == ~$past({4'b0000, dirs}))
		else count_fail("Bubbles mapping wrong");
	a_sin_ja: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::SINISTAR |=> cab.ja == ~$past(sin_ja))
		else count_fail("Sinistar stick code wrong");
	a_sin_fire: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::SINISTAR |=> cab.sin_fire == !$past(sh.fire_a))
		else count_fail("Sinistar fire wrong");
	a_sin_bomb: assert property (@(posedge clk_sys) disable iff (!arst_n)
		game == wms_pkg::SINISTAR |=> cab.sin_bomb == !$past(sh.fire_b))
		else count_fail("Sinistar bomb wrong");
	a_idle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!known_game |=> cab == {8'hFF, 8'hFF, 3'b000, 1'b1, 1'b1})
		else count_fail("unknown game left a control active");

	//////////////////////////////////////////////////////////////////////
	// Blanking
	a_hblank: assert property (@(posedge clk_sys) disable iff (!arst_n)
		hblank == $past(hbl_exp)) else count_fail("hblank wrong");
	a_vblank: assert property (@(posedge clk_sys) disable iff (!arst_n)
		vblank == $past(vbl_exp)) else count_fail("vblank wrong");

endmodule

`default_nettype wire

// ==== rtl/blank_gen.sv ====
/*
 * Blanking from sync pulses
 * Pixel/line counters restarted by hs and vs rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module blank_gen #(
	parameter int CNT_W = 11
)
(
	input  wire  clk_sys,
	input  wire  arst_n,
	input  wire  hs,
	input  wire  vs,
	output logic hblank,
	output logic vblank
);

	logic [CNT_W-1:0] pix_cnt;
	logic [CNT_W-1:0] line_cnt;
	logic             hs_q;
	logic             vs_q;
	logic             hs_rise;

	assign hs_rise = hs & ~hs_q;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix_cnt  <= '0;
			line_cnt <= '0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
		end
		else
		begin
			hs_q <= hs;
			if (!(&pix_cnt))
				pix_cnt <= pix_cnt + 1'b1;
			if (hs_rise)
			begin
				pix_cnt <= '0;
				// vs only sampled once per line
				vs_q    <= vs;
				if (vs && !vs_q)
					line_cnt <= '0;
				else if (!(&line_cnt))
					line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hblank <= 1'b1;
			vblank <= 1'b1;
		end
		else
		begin
			if (pix_cnt[CNT_W-1:1] == wms_pkg::HBLANK_START)
				hblank <= 1'b1;
			if (pix_cnt[CNT_W-1:1] == wms_pkg::HBLANK_END)
				hblank <= 1'b0;
			if (line_cnt == wms_pkg::VBLANK_START)
				vblank <= 1'b1;
			if (line_cnt == wms_pkg::VBLANK_END)
				vblank <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cfg_loader.sv ====
/*
 * Config write slave, four-phase req/ack
 * Stores game select and DIP switch byte 0
 */
`timescale 1ns/1ps
`default_nettype none

module cfg_loader
(
	input  wire              clk_sys,
	input  wire              arst_n,
	input  wire              cfg_req,
	input  wms_pkg::cfg_wr_t cfg_data,
	output logic             cfg_ack,
	output wms_pkg::game_e   game,
	output logic [7:0]       dip_sw
);

	typedef enum logic {
		ST_IDLE,
		ST_ACK
	} state_e;

	state_e state;

	assign cfg_ack = state == ST_ACK;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state  <= ST_IDLE;
			game   <= wms_pkg::ROBOTRON;
			dip_sw <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (cfg_req)
					begin
						// Write and acknowledge on the same edge
						if (cfg_data.index == wms_pkg::CFG_IDX_GAME)
							game <= wms_pkg::game_e'(cfg_data.data);
						if (cfg_data.index == wms_pkg::CFG_IDX_DIP && cfg_data.addr == 3'd0)
							dip_sw <= cfg_data.data;
						state <= ST_ACK;
					end
				ST_ACK:
					if (!cfg_req)
						state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/control_mapper.sv ====
/*
 * Merges keyboard and USB joysticks, maps them per game
 * onto registered cabinet control outputs
 */
`timescale 1ns/1ps
`default_nettype none

module control_mapper
(
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wms_pkg::game_e     game,
	input  wire                fire_mode,
	input  wms_pkg::player_t   kbd_p1,
	input  wms_pkg::player_t   kbd_p2,
	input  wire [2:0]          kbd_sys,
	input  wms_pkg::usb_joy_t  joy1,
	input  wms_pkg::usb_joy_t  joy2,
	input  wms_pkg::analog_t   stick,
	output wms_pkg::cab_ctrl_t cab
);

	wms_pkg::player_t   p1;
	wms_pkg::player_t   p2;
	wms_pkg::player_t   sh;
	wms_pkg::cab_ctrl_t cab_d;
	logic               start1;
	logic               start2;
	logic               coin;
	logic [3:0]         dig_x;
	logic [3:0]         dig_y;
	logic [3:0]         x_code;
	logic [3:0]         y_code;

	//////////////////////////////////////////////////////////////////////
	// Merge
	assign p1     = kbd_p1 | joy1.p;
	assign p2     = kbd_p2 | joy2.p;
	assign sh     = p1 | p2;
	assign start1 = kbd_sys[0] | joy1.start1 | joy2.start1;
	assign start2 = kbd_sys[1] | joy1.start2 | joy2.start2;
	assign coin   = kbd_sys[2] | joy1.coin | joy2.coin;

	// Digital request used when the analog stick sits centered
	assign dig_x = sh.left ? 4'd0 : sh.right ? 4'd8 : 4'd7;
	assign dig_y = sh.down ? 4'd0 : sh.up    ? 4'd8 : 4'd7;

	stick_quantizer stick_quantizer_inst
	(
		.stick  (stick),
		.dig_x  (dig_x),
		.dig_y  (dig_y),
		.x_code (x_code),
		.y_code (y_code)
	);

	//////////////////////////////////////////////////////////////////////
	// Per-game mapping
	always_comb
	begin
		cab_d.ja       = 8'hFF;
		cab_d.jb       = 8'hFF;
		cab_d.btn      = 3'b000;
		cab_d.sin_fire = 1'b1;
		cab_d.sin_bomb = 1'b1;
		case (game)
			wms_pkg::ROBOTRON:
			begin
				cab_d.btn = {start1, start2, coin};
				cab_d.ja  = ~{fire_mode ? {sh.right, sh.left, sh.down, sh.up}
				                        : {sh.fire_a, sh.fire_d, sh.fire_b, sh.fire_c},
				              sh.right, sh.left, sh.down, sh.up};
				cab_d.jb  = cab_d.ja;
			end
			wms_pkg::JOUST:
			begin
				cab_d.btn = {start2, start1, coin};
				cab_d.ja  = ~{5'b00000, p1.fire_a, p1.right, p1.left};
				cab_d.jb  = ~{5'b00000, p2.fire_a, p2.right, p2.left};
			end
			wms_pkg::BUBBLES:
			begin
				cab_d.btn = {start2, start1, coin};
				cab_d.ja  = ~{4'b0000, sh.right, sh.left, sh.down, sh.up};
				cab_d.jb  = cab_d.ja;
			end
			wms_pkg::SINISTAR:
			begin
				cab_d.btn      = {start1, start2, coin};
				cab_d.ja       = ~{x_code, y_code};
				cab_d.jb       = cab_d.ja;
				cab_d.sin_fire = ~sh.fire_a;
				cab_d.sin_bomb = ~sh.fire_b;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			cab <= '{ja: 8'hFF, jb: 8'hFF, btn: 3'b000, sin_fire: 1'b1, sin_bomb: 1'b1};
		else
			cab <= cab_d;
	end

endmodule

`default_nettype wire

// ==== rtl/kbd_decode.sv ====
/*
 * PS/2 key event decoder
 * Holds both players' keyboard buttons plus start and coin keys
 */
`timescale 1ns/1ps
`default_nettype none

module kbd_decode
(
	input  wire               clk_sys,
	input  wire               arst_n,
	input  wms_pkg::kbd_evt_t kbd,
	output wms_pkg::player_t  kbd_p1,
	output wms_pkg::player_t  kbd_p2,
	output logic [2:0]        kbd_sys
);

	logic tog_q;
	logic new_evt;

	assign new_evt = kbd.toggle != tog_q;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tog_q   <= 1'b0;
			kbd_p1  <= '0;
			kbd_p2  <= '0;
			kbd_sys <= '0;
		end
		else
		begin
			tog_q <= kbd.toggle;
			if (new_evt)
			begin
				case (kbd.code)
					// Player 1, cursor keys and left modifiers
					8'h75: kbd_p1.up     <= kbd.pressed;
					8'h72: kbd_p1.down   <= kbd.pressed;
					8'h6B: kbd_p1.left   <= kbd.pressed;
					8'h74: kbd_p1.right  <= kbd.pressed;
					8'h14: kbd_p1.fire_a <= kbd.pressed;
					8'h11: kbd_p1.fire_b <= kbd.pressed;
					8'h29: kbd_p1.fire_c <= kbd.pressed;
					8'h12: kbd_p1.fire_d <= kbd.pressed;
					// Player 2, MAME style layout
					8'h2D: kbd_p2.up     <= kbd.pressed;
					8'h2B: kbd_p2.down   <= kbd.pressed;
					8'h23: kbd_p2.left   <= kbd.pressed;
					8'h34: kbd_p2.right  <= kbd.pressed;
					8'h1C: kbd_p2.fire_a <= kbd.pressed;
					8'h1B: kbd_p2.fire_b <= kbd.pressed;
					8'h21: kbd_p2.fire_c <= kbd.pressed;
					8'h1D: kbd_p2.fire_d <= kbd.pressed;
					// kbd_sys is {coin, start2, start1}
					8'h05, 8'h16: kbd_sys[0] <= kbd.pressed;
					8'h06, 8'h1E: kbd_sys[1] <= kbd.pressed;
					8'h76, 8'h2E, 8'h36: kbd_sys[2] <= kbd.pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stick_quantizer.sv ====
/*
 * Sinistar 49-way stick quantizer
 * Analog axes to 4-bit codes, digital fallback when centered
 */
`timescale 1ns/1ps
`default_nettype none

module stick_quantizer
(
	input  wms_pkg::analog_t stick,
	input  wire [3:0]        dig_x,
	input  wire [3:0]        dig_y,
	output logic [3:0]       x_code,
	output logic [3:0]       y_code
);

	logic [3:0] ax;
	logic [3:0] ay;

	always_comb
	begin
		if      (stick.x < -96) ax = 4'd0;
		else if (stick.x < -64) ax = 4'd4;
		else if (stick.x < -32) ax = 4'd6;
		else if (stick.x >  96) ax = 4'd8;
		else if (stick.x >  64) ax = 4'd9;
		else if (stick.x >  32) ax = 4'd11;
		else                    ax = wms_pkg::STICK_CENTER;

		// Y table is mirrored
		if      (stick.y < -96) ay = 4'd8;
		else if (stick.y < -64) ay = 4'd9;
		else if (stick.y < -32) ay = 4'd11;
		else if (stick.y >  96) ay = 4'd0;
		else if (stick.y >  64) ay = 4'd4;
		else if (stick.y >  32) ay = 4'd6;
		else                    ay = wms_pkg::STICK_CENTER;
	end

	assign x_code = (ax == wms_pkg::STICK_CENTER) ? dig_x : ax;
	assign y_code = (ay == wms_pkg::STICK_CENTER) ? dig_y : ay;

endmodule

`default_nettype wire

// ==== rtl/wms_io_top.sv ====
/*
 * Cabinet-control top: keyboard decode, config loader,
 * control mapping and blanking generation
 */
`timescale 1ns/1ps
`default_nettype none

module wms_io_top #(
	parameter int CNT_W = 11
)
(
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wms_pkg::kbd_evt_t  kbd,
	input  wms_pkg::usb_joy_t  joy1,
	input  wms_pkg::usb_joy_t  joy2,
	input  wms_pkg::analog_t   stick,
	input  wire                fire_mode,
	input  wire                cfg_req,
	input  wms_pkg::cfg_wr_t   cfg_data,
	input  wire                hs,
	input  wire                vs,
	output logic               cfg_ack,
	output wms_pkg::cab_ctrl_t cab,
	output logic [7:0]         dip_sw,
	output logic               hblank,
	output logic               vblank
);

	wms_pkg::game_e   game;
	wms_pkg::player_t kbd_p1;
	wms_pkg::player_t kbd_p2;
	logic [2:0]       kbd_sys;

	kbd_decode kbd_decode_inst
	(
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.kbd     (kbd),
		.kbd_p1  (kbd_p1),
		.kbd_p2  (kbd_p2),
		.kbd_sys (kbd_sys)
	);

	cfg_loader cfg_loader_inst
	(
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.cfg_req  (cfg_req),
		.cfg_data (cfg_data),
		.cfg_ack  (cfg_ack),
		.game     (game),
		.dip_sw   (dip_sw)
	);

	control_mapper control_mapper_inst
	(
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.game      (game),
		.fire_mode (fire_mode),
		.kbd_p1    (kbd_p1),
		.kbd_p2    (kbd_p2),
		.kbd_sys   (kbd_sys),
		.joy1      (joy1),
		.joy2      (joy2),
		.stick     (stick),
		.cab       (cab)
	);

	blank_gen #(
		.CNT_W (CNT_W)
	) blank_gen_inst
	(
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank)
	);

endmodule

`default_nettype wire

// ==== rtl/wms_pkg.sv ====
/*
 * Shared types and constants for the cabinet-control block:
 * game select codes, player/joystick/key event structs,
 * cabinet control outputs, config write word and blanking limits
 */
`default_nettype none

package wms_pkg;

	// Game select codes as written through the config channel
	typedef enum logic [7:0] {
		ROBOTRON = 8'd0,
		JOUST    = 8'd1,
		BUBBLES  = 8'd3,
		SINISTAR = 8'd6
	} game_e;

	// One player's controls, active high
	typedef struct packed {
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef struct packed {
		logic    coin;
		logic    start2;
		logic    start1;
		player_t p;
	} usb_joy_t;

	// New event whenever toggle flips
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [7:0] code;
	} kbd_evt_t;

	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} analog_t;

	// Board side: ja/jb and the Sinistar buttons are active low
	typedef struct packed {
		logic [7:0] ja;
		logic [7:0] jb;
		logic [2:0] btn;
		logic       sin_fire;
		logic       sin_bomb;
	} cab_ctrl_t;

	typedef struct packed {
		logic [7:0] index;
		logic [2:0] addr;
		logic [7:0] data;
	} cfg_wr_t;

	localparam logic [7:0] CFG_IDX_GAME = 8'd1;
	localparam logic [7:0] CFG_IDX_DIP  = 8'd254;

	localparam logic [3:0] STICK_CENTER = 4'd7;

	// Horizontal limits in half-pixel counts, vertical in lines
	localparam logic [9:0]  HBLANK_START = 10'd336;
	localparam logic [9:0]  HBLANK_END   = 10'd40;
	localparam logic [10:0] VBLANK_START = 11'd246;
	localparam logic [10:0] VBLANK_END   = 11'd6;

endpackage

`default_nettype wire
